/* rtl/sw_ops_pkg.sv */
package sw_ops_pkg;

  // --------------------------------------------------
  // Software operation codes, one cycle wide
  // --------------------------------------------------
  typedef enum logic [3:0] {
    OP_NONE           = 4'd0,   // Idle bus
    OP_W_STATIC       = 4'd1,   // Write static control word
    OP_R_STATIC       = 4'd2,   // Read static control word
    OP_W_ARRAY        = 4'd3,   // Write one array word
    OP_R_ARRAY        = 4'd4,   // Read array word pair
    OP_R_DATA         = 4'd5,   // Read capture word
    OP_W_STATUS_CLEAR = 4'd6,
    OP_W_EXECUTE      = 4'd7    // Start a test
  } sw_op_t;

  // Config clock counter width
  localparam int PERIOD_W = 7;
  localparam logic [PERIOD_W-1:0] MIN_DELAY = 7'd3;   // Smallest usable shift point

  // --------------------------------------------------
  // Layouts of the 24-bit write word
  // --------------------------------------------------
  typedef struct packed {
    logic [15:0]         spare;             // Bits 23:8
    logic                super_pixel_sel;   // Bit 7
    logic [PERIOD_W-1:0] config_period;     // Bits 6:0, last counter value
  } static_cfg_t;

  typedef struct packed {
    logic                test_mask_reset_not;   // Bit 23, set to skip the chip reset pulse
    logic [3:0]          spare;
    logic                test_loopback;         // Capture own config_in
    logic [3:0]          test_number;
    logic [PERIOD_W-1:0] test_sample;           // Counter value for capture
    logic [PERIOD_W-1:0] test_delay;            // Counter value for shift
  } exec_cfg_t;

  typedef struct packed {
    logic [7:0]  addr;   // Also the read address for array and data reads
    logic [15:0] data;
  } array_wr_t;

  // Status word bit positions
  localparam int ST_RESET    = 0;
  localparam int ST_W_STATIC = 1;
  localparam int ST_R_STATIC = 2;
  localparam int ST_W_ARRAY  = 3;
  localparam int ST_R_ARRAY  = 4;
  localparam int ST_R_DATA   = 5;
  localparam int ST_EXECUTE  = 6;
  localparam int ST_DONE     = 7;    // Sticky
  localparam int ST_ERROR    = 31;   // Sticky, bad execute setting

endpackage

/* rtl/chip_cfg_pkg.sv */
package chip_cfg_pkg;

  // --------------------------------------------------
  // Test 1 sequencer states
  // --------------------------------------------------
  typedef enum logic [2:0] {
    IDLE       = 3'd0,   // Pins parked at their idle values
    RESET_CHIP = 3'd1,   // reset_not low unless masked
    LOAD_CHAIN = 3'd2,   // Parallel load of the output chain
    SHIFT      = 3'd3,   // Serial transfer on config_clk
    DONE       = 3'd4    // One cycle, raises the done pulse
  } seq_state_t;

  // Outputs towards the chip
  typedef struct packed {
    logic config_clk;
    logic reset_not;         // Active low chip reset
    logic config_in;         // Serial data to the chip
    logic config_load;       // Low while shifting
    logic super_pixel_sel;
  } chip_pins_t;

  // --------------------------------------------------
  // Sequencer to chain controls
  // --------------------------------------------------
  typedef struct packed {
    logic load;          // Copy array into output chain
    logic shift;         // Move output chain one bit right
    logic capture;       // Take capture_bit into capture register
    logic capture_bit;   // Gated by capture
  } chain_ctrl_t;

endpackage

/* rtl/cfg_regs.sv */
`timescale 1ns/1ps

module cfg_regs #(
  parameter int CFG_WORDS = 8
) (
  input  logic                           fw_axi_clk,
  input  logic                           op_code_w_reset,
  input  sw_ops_pkg::sw_op_t             op_code,
  input  logic [23:0]                    sw_write24,
  input  logic                           seq_done,       // One cycle at end of run
  input  logic                           cfg_error,      // Level from sequencer
  input  logic [31:0]                    capture_word,   // Already selected by address
  output sw_ops_pkg::static_cfg_t        static_cfg,
  output logic [CFG_WORDS-1:0][15:0]     cfg_array,
  output logic [31:0]                    fw_read_data32,
  output logic [31:0]                    fw_read_status32
);

  sw_ops_pkg::array_wr_t arr_wr;   // Address and data view of the write word
  logic [7:0]            rd_lo;    // Requested word, folded into range
  logic [7:0]            rd_hi;    // Next word with wrap

  assign arr_wr = sw_write24;

  // --------------------------------------------------
  // Write side
  // --------------------------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      static_cfg <= '0;   // Period 0 and super pixel off
    end else if (op_code == sw_ops_pkg::OP_W_STATIC) begin
      static_cfg <= sw_ops_pkg::static_cfg_t'(sw_write24);
    end
  end

  // Array words hold whatever software last wrote
  always_ff @(posedge fw_axi_clk) begin
    if (op_code == sw_ops_pkg::OP_W_ARRAY && int'(arr_wr.addr) < CFG_WORDS) begin
      cfg_array[arr_wr.addr] <= arr_wr.data;   // Out of range writes dropped
    end
  end

  // --------------------------------------------------
  // Read data mux, same cycle as the op code
  // --------------------------------------------------
  always_comb begin
    rd_lo = 8'(int'(arr_wr.addr) % CFG_WORDS);
    rd_hi = (int'(rd_lo) == CFG_WORDS - 1) ? 8'd0 : rd_lo + 8'd1;
    case (op_code)
      sw_ops_pkg::OP_R_STATIC: fw_read_data32 = {8'h00, static_cfg};   // Zero padded
      sw_ops_pkg::OP_R_ARRAY:  fw_read_data32 = {cfg_array[rd_hi], cfg_array[rd_lo]};
      sw_ops_pkg::OP_R_DATA:   fw_read_data32 = capture_word;
      default:                 fw_read_data32 = 32'h0;
    endcase
  end

  // --------------------------------------------------
  // Sticky status word
  // --------------------------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      fw_read_status32                       <= '0;
      fw_read_status32[sw_ops_pkg::ST_RESET] <= 1'b1;   // Only flag left after reset
    end else if (op_code == sw_ops_pkg::OP_W_STATUS_CLEAR) begin
      fw_read_status32 <= '0;
    end else begin
      case (op_code)
        sw_ops_pkg::OP_W_STATIC:  fw_read_status32[sw_ops_pkg::ST_W_STATIC] <= 1'b1;
        sw_ops_pkg::OP_R_STATIC:  fw_read_status32[sw_ops_pkg::ST_R_STATIC] <= 1'b1;
        sw_ops_pkg::OP_W_ARRAY:   fw_read_status32[sw_ops_pkg::ST_W_ARRAY]  <= 1'b1;
        sw_ops_pkg::OP_R_ARRAY:   fw_read_status32[sw_ops_pkg::ST_R_ARRAY]  <= 1'b1;
        sw_ops_pkg::OP_R_DATA:    fw_read_status32[sw_ops_pkg::ST_R_DATA]   <= 1'b1;
        sw_ops_pkg::OP_W_EXECUTE: fw_read_status32[sw_ops_pkg::ST_EXECUTE]  <= 1'b1;
        default: ;
      endcase
      if (seq_done) begin
        fw_read_status32[sw_ops_pkg::ST_DONE] <= 1'b1;
      end
      if (cfg_error) begin
        fw_read_status32[sw_ops_pkg::ST_ERROR] <= 1'b1;   // Returns after clear while level holds
      end
    end
  end

endmodule

/* rtl/config_chain.sv */
`timescale 1ns/1ps

module config_chain #(
  parameter int CFG_WORDS = 8
) (
  input  logic                       fw_axi_clk,
  input  logic                       op_code_w_reset,
  input  chip_cfg_pkg::chain_ctrl_t  chain_ctrl,
  input  logic [CFG_WORDS-1:0][15:0] cfg_array,
  input  logic [7:0]                 rd_addr,        // Capture word index
  output logic                       chain_bit0,     // Next bit towards the chip
  output logic [31:0]                capture_word
);

  localparam int CHAIN_W = CFG_WORDS * 16;
  localparam int NCAP    = CHAIN_W / 32;   // 32-bit capture words

  logic [CHAIN_W-1:0] out_chain;   // Word 0 sits at the low end
  logic [CHAIN_W-1:0] cap_reg;     // Filled from the MSB side

  // --------------------------------------------------
  // Output chain
  // --------------------------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      out_chain <= '0;                                 // Nothing to send yet
    end else if (chain_ctrl.load) begin
      out_chain <= cfg_array;                          // Flat copy of the array
    end else if (chain_ctrl.shift) begin
      out_chain <= {1'b0, out_chain[CHAIN_W-1:1]};     // LSB first, zero fill
    end
  end

  assign chain_bit0 = out_chain[0];

  // --------------------------------------------------
  // Capture register
  // --------------------------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (chain_ctrl.capture) begin
      cap_reg <= {chain_ctrl.capture_bit, cap_reg[CHAIN_W-1:1]};   // First bit ends at bit 0
    end
  end

  // Word select, zero past the last word
  assign capture_word = (int'(rd_addr) < NCAP) ? cap_reg[rd_addr*32 +: 32] : 32'h0;

endmodule

/* rtl/test1_sequencer.sv */
`timescale 1ns/1ps

module test1_sequencer #(
  parameter int CFG_WORDS = 8
) (
  input  logic                       fw_axi_clk,
  input  logic                       op_code_w_reset,
  input  sw_ops_pkg::sw_op_t         op_code,
  input  logic [23:0]                sw_write24,
  input  sw_ops_pkg::static_cfg_t    static_cfg,
  input  logic                       chain_bit0,
  input  logic                       config_out,   // Serial data back from the chip
  output chip_cfg_pkg::chain_ctrl_t  chain_ctrl,
  output chip_cfg_pkg::chip_pins_t   pins,
  output logic                       seq_done,
  output logic                       cfg_error
);

  localparam int CHAIN_W = CFG_WORDS * 16;
  localparam int SHW     = $clog2(CHAIN_W + 1);

  chip_cfg_pkg::seq_state_t              state;
  sw_ops_pkg::exec_cfg_t                 exec_in;     // Live view of the write word
  sw_ops_pkg::exec_cfg_t                 exec_reg;    // Held for the run
  logic [sw_ops_pkg::PERIOD_W-1:0]       cnt;         // Config clock phase
  logic [SHW-1:0]                        shift_cnt;
  logic                                  start_req;
  logic                                  delay_bad;
  logic                                  cnt_wrap;
  logic                                  clk_int;     // Free running config clock
  logic                                  shift_en;
  logic                                  cap_en;

  assign exec_in   = sw_write24;
  assign start_req = (op_code == sw_ops_pkg::OP_W_EXECUTE) && (exec_in.test_number == 4'd1)
                     && (state == chip_cfg_pkg::IDLE);
  assign delay_bad = (exec_in.test_delay < sw_ops_pkg::MIN_DELAY)
                     || (exec_in.test_delay > static_cfg.config_period);
  assign cnt_wrap  = cnt >= static_cfg.config_period;          // Also recovers from a lowered period
  assign clk_int   = cnt > (static_cfg.config_period >> 1);    // High in the upper half

  // --------------------------------------------------
  // Period counter
  // --------------------------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      cnt <= '0;
    end else if (start_req && !delay_bad) begin
      cnt <= '0;                            // Align run with a fresh period
    end else if (cnt_wrap) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  assign shift_en = (state == chip_cfg_pkg::SHIFT) && (cnt == exec_reg.test_delay);
  assign cap_en   = (state == chip_cfg_pkg::SHIFT) && (cnt == exec_reg.test_sample);

  // --------------------------------------------------
  // Test 1 FSM
  // --------------------------------------------------
  always_ff @(posedge fw_axi_clk) begin
    if (op_code_w_reset) begin
      state     <= chip_cfg_pkg::IDLE;
      exec_reg  <= '0;
      cfg_error <= 1'b0;
      shift_cnt <= '0;
    end else begin
      case (state)
        chip_cfg_pkg::IDLE: begin
          if (start_req) begin
            exec_reg  <= exec_in;
            cfg_error <= delay_bad;     // Held until the next test 1 execute
            if (!delay_bad) begin
              state <= chip_cfg_pkg::RESET_CHIP;
            end
          end
        end
        chip_cfg_pkg::RESET_CHIP: begin
          if (cnt_wrap) begin
            state <= chip_cfg_pkg::LOAD_CHAIN;   // One full period elapsed
          end
        end
        chip_cfg_pkg::LOAD_CHAIN: begin
          shift_cnt <= '0;
          state     <= chip_cfg_pkg::SHIFT;
        end
        chip_cfg_pkg::SHIFT: begin
          if (shift_en) begin
            shift_cnt <= shift_cnt + 1'b1;
            if (shift_cnt == SHW'(CHAIN_W - 1)) begin
              state <= chip_cfg_pkg::DONE;       // Last bit just left
            end
          end
        end
        chip_cfg_pkg::DONE: state <= chip_cfg_pkg::IDLE;
        default:            state <= chip_cfg_pkg::IDLE;
      endcase
    end
  end

  assign seq_done = (state == chip_cfg_pkg::DONE);

  // --------------------------------------------------
  // Pin and chain control decode
  // --------------------------------------------------
  always_comb begin
    pins.config_clk      = (state == chip_cfg_pkg::SHIFT) & clk_int;   // Forwarded only while shifting
    pins.reset_not       = !((state == chip_cfg_pkg::RESET_CHIP) && !exec_reg.test_mask_reset_not);
    pins.config_in       = (state == chip_cfg_pkg::SHIFT) & chain_bit0;
    pins.config_load     = (state != chip_cfg_pkg::SHIFT);
    pins.super_pixel_sel = (state != chip_cfg_pkg::IDLE) & static_cfg.super_pixel_sel;

    chain_ctrl.load        = (state == chip_cfg_pkg::LOAD_CHAIN);
    chain_ctrl.shift       = shift_en;
    chain_ctrl.capture     = cap_en;
    chain_ctrl.capture_bit = cap_en & (exec_reg.test_loopback ? pins.config_in : config_out);
  end

endmodule

/* rtl/chip_cfg_top.sv */
`timescale 1ns/1ps

module chip_cfg_top #(
  parameter int CFG_WORDS = 8     // Chain length in 16-bit words, even
) (
  input  logic               fw_axi_clk,
  input  logic               op_code_w_reset,
  input  sw_ops_pkg::sw_op_t op_code,
  input  logic [23:0]        sw_write24,
  input  logic               fw_config_out,
  output logic [31:0]        fw_read_data32,
  output logic [31:0]        fw_read_status32,
  output logic               fw_config_clk,
  output logic               fw_reset_not,
  output logic               fw_config_in,
  output logic               fw_config_load,
  output logic               fw_super_pixel_sel
);

  sw_ops_pkg::static_cfg_t    static_cfg;
  logic [CFG_WORDS-1:0][15:0] cfg_array;
  chip_cfg_pkg::chain_ctrl_t  chain_ctrl;
  chip_cfg_pkg::chip_pins_t   pins;
  logic                       chain_bit0;
  logic [31:0]                capture_word;
  logic                       seq_done;
  logic                       cfg_error;

  // --------------------------------------------------
  // Register file, chain and sequencer
  // --------------------------------------------------
  cfg_regs #(.CFG_WORDS(CFG_WORDS)) cfg_regs_inst (
    .fw_axi_clk       (fw_axi_clk),
    .op_code_w_reset  (op_code_w_reset),
    .op_code          (op_code),
    .sw_write24       (sw_write24),
    .seq_done         (seq_done),
    .cfg_error        (cfg_error),
    .capture_word     (capture_word),
    .static_cfg       (static_cfg),
    .cfg_array        (cfg_array),
    .fw_read_data32   (fw_read_data32),
    .fw_read_status32 (fw_read_status32)
  );

  config_chain #(.CFG_WORDS(CFG_WORDS)) config_chain_inst (
    .fw_axi_clk      (fw_axi_clk),
    .op_code_w_reset (op_code_w_reset),
    .chain_ctrl      (chain_ctrl),
    .cfg_array       (cfg_array),
    .rd_addr         (sw_write24[23:16]),   // Same address field as array reads
    .chain_bit0      (chain_bit0),
    .capture_word    (capture_word)
  );

  test1_sequencer #(.CFG_WORDS(CFG_WORDS)) test1_sequencer_inst (
    .fw_axi_clk      (fw_axi_clk),
    .op_code_w_reset (op_code_w_reset),
    .op_code         (op_code),
    .sw_write24      (sw_write24),
    .static_cfg      (static_cfg),
    .chain_bit0      (chain_bit0),
    .config_out      (fw_config_out),
    .chain_ctrl      (chain_ctrl),
    .pins            (pins),
    .seq_done        (seq_done),
    .cfg_error       (cfg_error)
  );

  // Pin bundle onto the chip ports
  assign fw_config_clk      = pins.config_clk;
  assign fw_reset_not       = pins.reset_not;
  assign fw_config_in       = pins.config_in;
  assign fw_config_load     = pins.config_load;
  assign fw_super_pixel_sel = pins.super_pixel_sel;

endmodule

/* tests/chip_cfg_assert.sv */
`timescale 1ns/1ps

module chip_cfg_assert (
  input logic                     fw_axi_clk,
  input logic                     op_code_w_reset,
  input chip_cfg_pkg::seq_state_t state,
  input chip_cfg_pkg::chip_pins_t pins,
  input logic                     start_req,
  input logic                     delay_bad,
  input logic                     cfg_error
);

  // --------------------------------------------------
  // Pin rules of the test 1 FSM
  // --------------------------------------------------
  load_fall_after_load: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    $fell(pins.config_load) |-> $past(state) == chip_cfg_pkg::LOAD_CHAIN   // Shift opens after load
  ) else $error("config_load fell without a chain load");

  // Chip reset only as the answer to an accepted execute
  reset_fall_on_start: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    $fell(pins.reset_not) |-> $past(start_req && !delay_bad)
  ) else $error("reset_not fell without an accepted execute");

  // Rejected execute keeps the FSM parked
  bad_exec_stays_idle: assert property (@(posedge fw_axi_clk) disable iff (op_code_w_reset)
    start_req && delay_bad |=> cfg_error && state == chip_cfg_pkg::IDLE
  ) else $error("FSM left IDLE on a rejected execute");

endmodule

bind test1_sequencer chip_cfg_assert chip_cfg_assert_inst (
  .fw_axi_clk      (fw_axi_clk),
  .op_code_w_reset (op_code_w_reset),
  .state           (state),
  .pins            (pins),
  .start_req       (start_req),
  .delay_bad       (delay_bad),
  .cfg_error       (cfg_error)
);

/* tests/chip_cfg_tb.sv */
`timescale 1ns/1ps

module chip_cfg_tb;

  localparam int CFG_WORDS   = 8;
  localparam int PERIOD      = 15;                                    // Config clock period used
  localparam int RUN_CYCLES  = (CFG_WORDS * 16 + 4) * (PERIOD + 1);   // Upper bound for one run
  localparam int N_RUNS      = 2;
  localparam int WATCHDOG_NS = RUN_CYCLES * 4 * N_RUNS + 5000;       // Margin for setup and reads

  logic               fw_axi_clk;
  logic               op_code_w_reset;
  sw_ops_pkg::sw_op_t op_code;
  logic [23:0]        sw_write24;
  logic               fw_config_out;
  logic [31:0]        fw_read_data32;
  logic [31:0]        fw_read_status32;
  logic               fw_config_clk;
  logic               fw_reset_not;
  logic               fw_config_in;
  logic               fw_config_load;
  logic               fw_super_pixel_sel;

  logic [15:0] exp_array [CFG_WORDS];   // Reference copy of the array
  logic [31:0] lfsr;
  int          errors;
  int          checks;

  chip_cfg_top #(.CFG_WORDS(CFG_WORDS)) chip_cfg_top_inst (.*);

  always #2 fw_axi_clk = ~fw_axi_clk;   // 4 ns period

  // --------------------------------------------------
  // Compare tasks and stimulus helpers
  // --------------------------------------------------
  task automatic check_word32(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_pin(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s got %b expected %b", $time, name, got, exp);
    end
  endtask

  // Galois LFSR, one step per bit taken
  function automatic logic [15:0] rand_word();
    logic [15:0] w;
    for (int i = 0; i < 16; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
      w[i] = lfsr[0];
    end
    return w;
  endfunction

  function automatic logic [23:0] exec_word(input logic loopback, input logic [6:0] delay);
    sw_ops_pkg::exec_cfg_t w;
    w               = '0;
    w.test_number   = 4'd1;
    w.test_loopback = loopback;
    w.test_delay    = delay;
    w.test_sample   = 7'd2;   // Capture ahead of the shift point
    return w;
  endfunction

  // One op for one cycle, read data sampled mid cycle
  task automatic issue(input sw_ops_pkg::sw_op_t op, input logic [23:0] word,
                       output logic [31:0] rdata);
    @(posedge fw_axi_clk);
    #1;
    op_code    = op;
    sw_write24 = word;
    #1;
    rdata = fw_read_data32;
    @(posedge fw_axi_clk);
    #1;
    op_code    = sw_ops_pkg::OP_NONE;   // Status now shows the op
    sw_write24 = '0;
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic test_static_rw();
    logic [31:0] rd;
    logic [23:0] word;
    word = {16'ha5c3, 1'b1, 7'(PERIOD)};   // Spare bits set, super pixel on
    issue(sw_ops_pkg::OP_W_STATIC, word, rd);
    issue(sw_ops_pkg::OP_R_STATIC, '0, rd);
    check_word32("fw_read_data32", rd, {8'h00, word});
    check_word32("fw_read_status32", fw_read_status32, 32'h0000_0007);
    issue(sw_ops_pkg::OP_W_STATUS_CLEAR, '0, rd);
    check_word32("fw_read_status32", fw_read_status32, 32'h0);
  endtask

  task automatic test_array_rw();
    logic [31:0] rd;
    for (int a = 0; a < CFG_WORDS; a++) begin
      exp_array[a] = rand_word();
      issue(sw_ops_pkg::OP_W_ARRAY, {8'(a), exp_array[a]}, rd);
    end
    for (int a = 0; a < CFG_WORDS; a++) begin
      issue(sw_ops_pkg::OP_R_ARRAY, {8'(a), 16'h0}, rd);
      check_word32("fw_read_data32", rd, {exp_array[(a + 1) % CFG_WORDS], exp_array[a]});
    end
    check_word32("fw_read_status32", fw_read_status32, 32'h0000_0018);
  endtask

  task automatic test_run(input logic loopback);
    logic [31:0] rd;
    logic [31:0] exp;
    logic        done;
    logic        rst_seen;
    logic        load_seen;
    logic        clk_seen;
    logic        sps_seen;
    int          cycles;
    issue(sw_ops_pkg::OP_W_STATUS_CLEAR, '0, rd);
    issue(sw_ops_pkg::OP_W_EXECUTE, exec_word(loopback, 7'd6), rd);
    done      = 1'b0;
    rst_seen  = 1'b0;
    load_seen = 1'b0;
    clk_seen  = 1'b0;
    sps_seen  = 1'b0;
    cycles    = 0;
    while (!done && cycles < RUN_CYCLES) begin   // Poll ST_DONE
      done      = fw_read_status32[sw_ops_pkg::ST_DONE];
      rst_seen  |= !fw_reset_not;
      load_seen |= !fw_config_load;
      clk_seen  |= fw_config_clk;
      sps_seen  |= fw_super_pixel_sel;
      @(posedge fw_axi_clk);
      #1;
      cycles++;
    end
    if (!done) begin
      errors++;
      $display("Test 1 run did not finish within %0d cycles", RUN_CYCLES);
    end
    check_pin("fw_reset_not pulse", rst_seen, 1'b1);
    check_pin("fw_config_load shift phase", load_seen, 1'b1);
    check_pin("fw_config_clk toggle", clk_seen, 1'b1);
    check_pin("fw_super_pixel_sel in run", sps_seen, 1'b1);   // Static word has it set
    check_word32("fw_read_status32", fw_read_status32, 32'h0000_00c0);
    check_pin("fw_config_load", fw_config_load, 1'b1);   // Parked again
    check_pin("fw_config_clk", fw_config_clk, 1'b0);
    for (int i = 0; i < CFG_WORDS / 2; i++) begin
      issue(sw_ops_pkg::OP_R_DATA, {8'(i), 16'h0}, rd);
      exp = loopback ? {exp_array[2 * i + 1], exp_array[2 * i]} : 32'hffff_ffff;
      check_word32("fw_read_data32", rd, exp);
    end
    issue(sw_ops_pkg::OP_R_DATA, {8'(CFG_WORDS / 2), 16'h0}, rd);   // Past last word
    check_word32("fw_read_data32", rd, 32'h0);
  endtask

  task automatic test_bad_exec(input logic [6:0] delay);
    logic [31:0] rd;
    issue(sw_ops_pkg::OP_W_STATUS_CLEAR, '0, rd);
    issue(sw_ops_pkg::OP_W_EXECUTE, exec_word(1'b0, delay), rd);
    repeat (2 * (PERIOD + 1)) begin   // FSM must stay parked
      check_pin("fw_config_load", fw_config_load, 1'b1);
      @(posedge fw_axi_clk);
      #1;
    end
    check_word32("fw_read_status32", fw_read_status32, 32'h8000_0040);
  endtask

  // --------------------------------------------------
  // Watchdog and main sequence
  // --------------------------------------------------
  initial begin : watchdog
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, run is stuck", WATCHDOG_NS);
    $display("Simulation finished: FAIL");
    $finish;
  end

  initial begin
    fw_axi_clk      = 1'b0;
    op_code_w_reset = 1'b1;
    op_code         = sw_ops_pkg::OP_NONE;
    sw_write24      = '0;
    fw_config_out   = 1'b0;
    lfsr            = 32'hc8d2_5d97;
    errors          = 0;
    checks          = 0;
    repeat (10) @(posedge fw_axi_clk);
    #1;
    op_code_w_reset = 1'b0;
    check_word32("fw_read_status32", fw_read_status32, 32'h0000_0001);   // ST_RESET only
    check_pin("fw_config_clk", fw_config_clk, 1'b0);
    check_pin("fw_reset_not", fw_reset_not, 1'b1);
    check_pin("fw_config_in", fw_config_in, 1'b0);
    check_pin("fw_config_load", fw_config_load, 1'b1);
    check_pin("fw_super_pixel_sel", fw_super_pixel_sel, 1'b0);
    test_static_rw();
    test_array_rw();
    test_run(1'b1);          // Loopback capture
    fw_config_out = 1'b1;    // Chip answers all ones
    test_run(1'b0);
    test_bad_exec(7'd2);     // Below minimum delay
    test_bad_exec(7'd20);    // Beyond the period
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* sim.f */
rtl/sw_ops_pkg.sv
rtl/chip_cfg_pkg.sv
rtl/cfg_regs.sv
rtl/config_chain.sv
rtl/test1_sequencer.sv
rtl/chip_cfg_top.sv
tests/chip_cfg_assert.sv
tests/chip_cfg_tb.sv
